// ==== credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 8
) (
	input logic clk,
	input logic bit_ctr_reset,
	input logic push,
	input payload_t wdata,
	input logic pop,
	output payload_t rdata,
	output logic empty,
	output logic credit
);

	payload_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_pop;

	assign empty = (count == '0);
	assign do_pop = pop && !empty;
	assign rdata = mem[rd_ptr]; // head is visible without a pop.

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= do_pop; // one credit back per entry consumed.
			if (push)
				wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the host only pushes on a held credit, so a push never
	// finds the buffer full.

endmodule

`default_nettype wire

// ==== ein_bit_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_bit_shifter (
	input logic clk,
	input logic bit_ctr_reset,
	input logic bit_step,
	input logic frame_start,
	input ein_frame_pkg::ein_byte_t fifo_data,
	input logic fifo_empty,
	output logic fifo_pop,
	output logic cur_bit,
	output logic byte_ready,
	output logic byte_done
);

	import ein_frame_pkg::*;

	logic [$clog2($bits(ein_byte_t))-1:0] bit_idx;
	logic last_bit;

	assign last_bit = &bit_idx;

	// the byte stays at the fifo head until its last bit is stepped.
	assign cur_bit = fifo_data[bit_idx]; // lsb first.
	assign byte_ready = !fifo_empty;

	assign byte_done = bit_step && last_bit;
	assign fifo_pop = byte_done;

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			bit_idx <= '0;
		end else if (frame_start) begin
			bit_idx <= '0;
		end else if (bit_step) begin
			bit_idx <= bit_idx + 1'b1; // wraps to bit 0 of the next byte.
		end
	end

endmodule

`default_nettype wire

// ==== ein_cfg_pkg.sv ====
`default_nettype none

package ein_cfg_pkg;

	// clock divisor, counted in clk cycles per phase.
	localparam int clk_div_w = 22;

	// fifo depths, which are also the host's starting credits.
	localparam int data_fifo_depth = 8;
	localparam int desc_fifo_depth = 4;

	localparam int byte_count_w = 8; // bytes per frame.

endpackage

`default_nettype wire

// ==== ein_frame_pkg.sv ====
`default_nettype none

package ein_frame_pkg;

	typedef logic [7:0] ein_byte_t;

	// one frame, byte_count is never zero.
	typedef struct packed {
		logic [ein_cfg_pkg::byte_count_w-1:0] byte_count;
		logic goc_mode; // five phases per bit.
		logic fragment; // emo stays high after the frame.
	} ein_desc_t;

	typedef struct packed {
		logic emo;
		logic edi;
		logic eci;
	} ein_lines_t;

	typedef enum logic [2:0] {
		idle,
		start,
		eci_neg1,
		eci_neg2,
		eci_pos1,
		eci_pos1_2,
		eci_pos2,
		frag_wait
	} ein_state_t;

endpackage

`default_nettype wire

// ==== ein_phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_phase_timer (
	input logic clk,
	input logic bit_ctr_reset,
	input logic phase_restart,
	input logic [ein_cfg_pkg::clk_div_w-1:0] clk_div,
	output logic phase_end,
	output logic bit_advance
);

	import ein_cfg_pkg::*;

	logic [clk_div_w-1:0] phase_cnt;

	// last cycle of a phase.
	assign phase_end = (phase_cnt == clk_div - clk_div_w'(1));

	// two cycles early, so the next byte is at the fifo head
	// before the following bit starts.
	assign bit_advance = (phase_cnt == clk_div - clk_div_w'(3));

	always_ff @(posedge clk) begin
		if (bit_ctr_reset)
			phase_cnt <= '0;
		else if (phase_restart || phase_end)
			phase_cnt <= '0;
		else
			phase_cnt <= phase_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// ==== ein_tx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_tx_ctrl (
	input logic clk,
	input logic bit_ctr_reset,
	input ein_frame_pkg::ein_desc_t desc,
	input logic desc_empty,
	output logic desc_pop,
	input logic phase_end,
	input logic bit_advance,
	output logic phase_restart,
	output logic bit_step,
	output logic frame_start,
	input logic cur_bit,
	input logic byte_ready,
	input logic byte_done,
	output ein_frame_pkg::ein_lines_t lines
);

	import ein_frame_pkg::*;

	ein_state_t state;
	ein_state_t next_state;
	ein_desc_t cur_desc;
	ein_lines_t next_lines;
	logic frame_over;

	// byte_count runs down to zero during the last byte.
	assign frame_over = (cur_desc.byte_count == '0);

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			state <= idle;
			cur_desc <= '0;
			lines <= '0;
		end else begin
			state <= next_state;
			lines <= next_lines; // lines trail the state by one cycle.
			if (desc_pop)
				cur_desc <= desc;
			else if (byte_done)
				cur_desc.byte_count <= cur_desc.byte_count - 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		next_lines.emo = 1'b1;
		next_lines.edi = 1'b0;
		next_lines.eci = 1'b0;
		desc_pop = 1'b0;
		phase_restart = 1'b0;
		bit_step = 1'b0;
		frame_start = 1'b0;
		case (state)
			idle, frag_wait: begin
				next_lines.emo = (state == frag_wait);
				phase_restart = 1'b1; // start gets a full phase.
				if (!desc_empty) begin
					desc_pop = 1'b1;
					next_state = start;
				end
			end
			start: begin
				frame_start = 1'b1;
				if (phase_end)
					next_state = eci_neg1;
			end
			eci_neg1: begin
				next_lines.edi = cur_desc.goc_mode ? 1'b1 : lines.edi;
				if (!byte_ready)
					phase_restart = 1'b1; // wait here for data.
				else if (phase_end)
					next_state = eci_neg2;
			end
			eci_neg2: begin
				next_lines.edi = cur_bit;
				if (phase_end)
					next_state = eci_pos1;
			end
			eci_pos1: begin
				next_lines.eci = 1'b1;
				next_lines.edi = cur_bit;
				if (phase_end)
					next_state = cur_desc.goc_mode ? eci_pos1_2 : eci_pos2;
			end
			eci_pos1_2: begin
				// eci stays high, one rising edge per goc bit.
				next_lines.eci = 1'b1;
				next_lines.edi = cur_bit;
				if (phase_end)
					next_state = eci_pos2;
			end
			eci_pos2: begin
				next_lines.eci = 1'b1;
				next_lines.edi = lines.edi; // held while the bit index moves.
				if (bit_advance)
					bit_step = 1'b1;
				else if (phase_end) begin
					if (!frame_over)
						next_state = eci_neg1;
					else if (cur_desc.fragment)
						next_state = frag_wait;
					else
						next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== ein_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_tx_top (
	input logic clk,
	input logic bit_ctr_reset,
	input logic [ein_cfg_pkg::clk_div_w-1:0] clk_div,
	input logic data_push,
	input ein_frame_pkg::ein_byte_t data_in,
	output logic data_credit,
	input logic desc_push,
	input ein_frame_pkg::ein_desc_t desc_in,
	output logic desc_credit,
	output ein_frame_pkg::ein_lines_t lines
);

	import ein_cfg_pkg::*;
	import ein_frame_pkg::*;

	ein_byte_t data_rdata;
	logic data_empty;
	logic data_pop;
	ein_desc_t desc_rdata;
	logic desc_empty;
	logic desc_pop;
	logic phase_restart;
	logic phase_end;
	logic bit_advance;
	logic bit_step;
	logic frame_start;
	logic cur_bit;
	logic byte_ready;
	logic byte_done;

	credit_fifo #(
		.payload_t(ein_byte_t),
		.depth(data_fifo_depth)
	) u_data_fifo (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.push(data_push),
		.wdata(data_in),
		.pop(data_pop),
		.rdata(data_rdata),
		.empty(data_empty),
		.credit(data_credit)
	);

	credit_fifo #(
		.payload_t(ein_desc_t),
		.depth(desc_fifo_depth)
	) u_desc_fifo (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.push(desc_push),
		.wdata(desc_in),
		.pop(desc_pop),
		.rdata(desc_rdata),
		.empty(desc_empty),
		.credit(desc_credit)
	);

	ein_phase_timer u_timer (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.phase_restart(phase_restart),
		.clk_div(clk_div),
		.phase_end(phase_end),
		.bit_advance(bit_advance)
	);

	ein_bit_shifter u_shifter (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.bit_step(bit_step),
		.frame_start(frame_start),
		.fifo_data(data_rdata),
		.fifo_empty(data_empty),
		.fifo_pop(data_pop),
		.cur_bit(cur_bit),
		.byte_ready(byte_ready),
		.byte_done(byte_done)
	);

	ein_tx_ctrl u_ctrl (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.desc(desc_rdata),
		.desc_empty(desc_empty),
		.desc_pop(desc_pop),
		.phase_end(phase_end),
		.bit_advance(bit_advance),
		.phase_restart(phase_restart),
		.bit_step(bit_step),
		.frame_start(frame_start),
		.cur_bit(cur_bit),
		.byte_ready(byte_ready),
		.byte_done(byte_done),
		.lines(lines)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --top-module tb_ein_tx -f tb.f > build.log 2>&1 &&
	./obj_dir/Vtb_ein_tx > sim.log 2>&1 ||
	{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "pass message missing in sim.log"; exit 1; }
echo "done, see sim.log"

// ==== tb.f ====
ein_cfg_pkg.sv
ein_frame_pkg.sv
credit_fifo.sv
ein_phase_timer.sv
ein_bit_shifter.sv
ein_tx_ctrl.sv
ein_tx_top.sv
tb_ein_tx.sv

// ==== tb_ein_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ein_tx;

	import ein_cfg_pkg::*;
	import ein_frame_pkg::*;

	typedef struct packed {
		logic edi;
		logic emo;
		logic mid; // edi in the middle of the first low phase.
		logic [31:0] cyc;
	} edge_rec_t;

	logic clk = 1'b0;
	logic bit_ctr_reset;
	logic [clk_div_w-1:0] clk_div;
	logic data_push;
	ein_byte_t data_in;
	logic data_credit;
	logic desc_push;
	ein_desc_t desc_in;
	logic desc_credit;
	ein_lines_t lines;

	int seed;
	int cd;
	int cyc = 0;
	int wait_limit = 5000;
	int data_pushes;
	int desc_pushes;
	int data_pulses;
	int desc_pulses;
	int edges_seen;
	int frame_len[$];
	logic frame_goc[$];
	logic frame_frag[$];
	ein_byte_t byte_q[$];
	logic exp_bit[$];
	int exp_gap[$];
	logic exp_goc[$];
	edge_rec_t recs[$];
	int emo_falls[$];
	edge_rec_t mrec;
	ein_lines_t prev_lines;
	logic [63:0] edi_hist;

	ein_tx_top uut (
		.clk(clk),
		.bit_ctr_reset(bit_ctr_reset),
		.clk_div(clk_div),
		.data_push(data_push),
		.data_in(data_in),
		.data_credit(data_credit),
		.desc_push(desc_push),
		.desc_in(desc_in),
		.desc_credit(desc_credit),
		.lines(lines)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// link decoder, sampled at negedge where the lines are stable.
	always @(negedge clk) begin
		if (bit_ctr_reset) begin
			recs.delete();
			emo_falls.delete();
			edges_seen = 0;
			data_pulses = 0;
			desc_pulses = 0;
		end else begin
			if (!prev_lines.eci && lines.eci) begin
				mrec.edi = lines.edi;
				mrec.emo = lines.emo;
				mrec.mid = edi_hist[6'(cyc - 2 * cd + cd / 2)]; // neg1 sits two phases back.
				mrec.cyc = cyc;
				recs.push_back(mrec);
				edges_seen++;
			end
			if (prev_lines.emo && !lines.emo)
				emo_falls.push_back(edges_seen);
			if (data_credit)
				data_pulses++;
			if (desc_credit)
				desc_pulses++;
		end
		edi_hist[6'(cyc)] = lines.edi;
		prev_lines = lines;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_quiet();
		assert (lines == '0 && !data_credit && !desc_credit)
			else fail_now($sformatf("ERR lines/credits got 0x%0h expected 0x0",
				{lines, data_credit, desc_credit}));
	endtask

	task automatic apply_reset();
		int i;
		bit_ctr_reset = 1'b1;
		for (i = 0; i < 5; i++) begin
			next_cycle();
			check_quiet();
		end
		bit_ctr_reset = 1'b0;
		next_cycle();
		check_quiet(); // idle with both fifos empty.
	endtask

	task automatic make_frames(input int n);
		int k;
		int j;
		frame_len.delete();
		frame_goc.delete();
		frame_frag.delete();
		byte_q.delete();
		for (k = 0; k < n; k++) begin
			frame_len.push_back(1 + ($random(seed) & 3));
			frame_goc.push_back(($random(seed) & 1) != 0);
			frame_frag.push_back(k != n - 1 && ($random(seed) & 1) != 0); // last one ends idle.
			for (j = 0; j < frame_len[k]; j++)
				byte_q.push_back(ein_byte_t'($random(seed)));
		end
	endtask

	// expected edi per eci rising edge, lsb first, and the gap before it.
	function automatic void build_expected(input int div);
		int k;
		int j;
		int i;
		int p;
		ein_byte_t b;
		exp_bit.delete();
		exp_gap.delete();
		exp_goc.delete();
		p = 0;
		for (k = 0; k < frame_len.size(); k++) begin
			for (j = 0; j < frame_len[k]; j++) begin
				for (i = 0; i < 8; i++) begin
					b = byte_q[p] >> i;
					exp_bit.push_back(b[0]);
					exp_gap.push_back((j == 0 && i == 0) ? 0 : (frame_goc[k] ? 5 : 4) * div);
					exp_goc.push_back(frame_goc[k]);
				end
				p++;
			end
		end
	endfunction

	function automatic logic fall_after_frame(input int n);
		int cum;
		int k;
		cum = 0;
		for (k = 0; k < frame_len.size(); k++) begin
			cum += 8 * frame_len[k];
			if (cum == n)
				return !frame_frag[k];
		end
		return 1'b0;
	endfunction

	function automatic logic has_credit(input logic for_desc);
		if (for_desc)
			return desc_pushes - desc_pulses < desc_fifo_depth;
		return data_pushes - data_pulses < data_fifo_depth;
	endfunction

	task automatic wait_credit(input logic for_desc);
		int waited;
		waited = 0;
		while (!has_credit(for_desc)) begin
			next_cycle();
			waited++;
			assert (waited < wait_limit) else fail_now("timed out waiting for a FIFO credit");
		end
	endtask

	// bytes of a frame go in before its descriptor.
	task automatic push_frames();
		int k;
		int j;
		int p;
		ein_desc_t d;
		p = 0;
		for (k = 0; k < frame_len.size(); k++) begin
			for (j = 0; j < frame_len[k]; j++) begin
				wait_credit(1'b0);
				data_in = byte_q[p];
				data_push = 1'b1;
				data_pushes++;
				next_cycle();
				data_push = 1'b0;
				p++;
			end
			d.byte_count = byte_count_w'(frame_len[k]);
			d.goc_mode = frame_goc[k];
			d.fragment = frame_frag[k];
			wait_credit(1'b1);
			desc_in = d;
			desc_push = 1'b1;
			desc_pushes++;
			next_cycle();
			desc_push = 1'b0;
		end
	endtask

	task automatic compare_records();
		edge_rec_t r;
		int waited;
		int last_cyc;
		int i;
		int n_plain;
		last_cyc = 0;
		for (i = 0; i < exp_bit.size(); i++) begin
			waited = 0;
			while (recs.size() == 0) begin
				@(negedge clk);
				waited++;
				assert (waited < wait_limit) else fail_now("timed out waiting for an eci rising edge");
			end
			r = recs.pop_front();
			assert (r.edi == exp_bit[i])
				else fail_now($sformatf("ERR edi bit %0d got 0x%0h expected 0x%0h",
					i, r.edi, exp_bit[i]));
			assert (r.emo) else fail_now($sformatf("ERR emo bit %0d got 0x0 expected 0x1", i));
			if (exp_gap[i] != 0)
				assert (int'(r.cyc) - last_cyc == exp_gap[i])
					else fail_now($sformatf("ERR eci period got 0x%0h expected 0x%0h",
						int'(r.cyc) - last_cyc, exp_gap[i]));
			if (exp_goc[i])
				assert (r.mid)
					else fail_now($sformatf("ERR edi goc phase bit %0d got 0x0 expected 0x1",
						i));
			last_cyc = int'(r.cyc);
		end
		waited = 0;
		while (lines.emo) begin
			@(negedge clk);
			waited++;
			assert (waited < wait_limit) else fail_now("emo never dropped after the last frame");
		end
		@(negedge clk);
		assert (recs.size() == 0) else fail_now("eci rose after the last expected bit");
		n_plain = 0;
		for (i = 0; i < frame_frag.size(); i++)
			if (!frame_frag[i])
				n_plain++;
		assert (emo_falls.size() == n_plain)
			else fail_now($sformatf("ERR emo falls got 0x%0h expected 0x%0h",
				emo_falls.size(), n_plain));
		for (i = 0; i < emo_falls.size(); i++)
			assert (fall_after_frame(emo_falls[i])) else fail_now("emo dropped inside a transfer");
	endtask

	task automatic run_pass(input int div);
		next_cycle();
		cd = div;
		clk_div = clk_div_w'(div);
		data_pushes = 0;
		desc_pushes = 0;
		apply_reset();
		make_frames(10);
		build_expected(div);
		fork
			push_frames();
			compare_records();
		join
		// every credit spent on a push has come back.
		assert (data_pulses == data_pushes && desc_pulses == desc_pushes)
			else fail_now($sformatf("ERR credit pulses got 0x%0h 0x%0h expected 0x%0h 0x%0h",
				data_pulses, desc_pulses, data_pushes, desc_pushes));
	endtask

	initial begin
		seed = 32'hc847164f;
		clk_div = clk_div_w'(4);
		data_push = 1'b0;
		data_in = '0;
		desc_push = 1'b0;
		desc_in = '0;
		bit_ctr_reset = 1'b1;
		run_pass(4);
		run_pass(7);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
